// ==== rtl/commit_pkg.sv ====
// Commit stage definitions

package commit_pkg;

  // ------------------------------------------------------------
  // widths and port count
  // ------------------------------------------------------------

  // integer data path
  localparam int XLEN = 32;
  // virtual address width of the pc
  localparam int VLEN = 32;
  // pairing rules below are written for exactly two ports
  localparam int NR_COMMIT_PORTS = 2;
  // x0..x31
  localparam int REG_ADDR_BITS = 5;
  // scoreboard depth of eight entries
  localparam int TRANS_ID_BITS = 3;
  // exception cause code
  localparam int CAUSE_BITS = 5;

  // ------------------------------------------------------------
  // functional unit of a scoreboard entry
  // ------------------------------------------------------------

  typedef enum logic [2:0] {
    FU_NONE      = 3'd0,
    FU_ALU       = 3'd1,
    FU_LOAD      = 3'd2,
    FU_STORE     = 3'd3,
    FU_CTRL_FLOW = 3'd4,
    FU_MULT      = 3'd5,
    FU_CSR       = 3'd6
  } fu_e;

  // ------------------------------------------------------------
  // operation of a scoreboard entry
  // ------------------------------------------------------------

  // OP_ADD doubles as the CSR no-op towards the CSR file
  typedef enum logic [2:0] {
    OP_ADD     = 3'd0,
    OP_CSRRW   = 3'd1,
    OP_CSRRS   = 3'd2,
    OP_CSRRC   = 3'd3,
    OP_FENCE   = 3'd4,
    OP_FENCE_I = 3'd5,
    OP_OTHER   = 3'd6
  } op_e;

endpackage

// ==== rtl/commit_port_decode.sv ====
// Commit port decoder

`timescale 1ns/1ps

module commit_port_decode
  import commit_pkg::*;
(
  input  logic valid_i,
  input  fu_e  fu_i,
  input  op_e  op_i,
  input  logic ex_valid_i,
  input  logic drop_i,
  input  logic lsu_ready_i,
  input  logic no_st_pending_i,
  output logic retire_ok_o,
  output logic gpr_write_o,
  output logic lsu_commit_o,
  output logic fence_o,
  output logic fence_i_o,
  output logic is_csr_o,
  output logic pairable_o
);

  logic is_store;
  logic is_fence_op;
  // entry that is valid and carries no exception
  logic clean;

  assign is_store    = (fu_i == FU_STORE);
  assign is_fence_op = (op_i == OP_FENCE) || (op_i == OP_FENCE_I);
  assign clean       = valid_i && !ex_valid_i;

  // ------------------------------------------------------------
  // stand-alone retire readiness
  // ------------------------------------------------------------
  // program order, halt and csr exceptions are left to the sequencer
  always_comb begin
    retire_ok_o = 1'b0;
    if (valid_i) begin
      if (ex_valid_i) begin
        // a faulting entry only leaves when it was cancelled
        retire_ok_o = drop_i;
      end else begin
        retire_ok_o = 1'b1;
        // store buffer full, hold the entry
        if (is_store && !lsu_ready_i) begin
          retire_ok_o = 1'b0;
        end
        // fences wait for the store buffer to drain
        if (is_fence_op && !drop_i && !no_st_pending_i) begin
          retire_ok_o = 1'b0;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // side effects
  // ------------------------------------------------------------
  always_comb begin
    // cancelled entries still retire but leave the register file alone
    gpr_write_o  = clean && !drop_i;
    // store commit does not look at drop
    lsu_commit_o = clean && is_store && lsu_ready_i;
    fence_o      = clean && !drop_i && (op_i == OP_FENCE) && no_st_pending_i;
    fence_i_o    = clean && !drop_i && (op_i == OP_FENCE_I) && no_st_pending_i;
    // blocks pairing even for an invalid slot
    is_csr_o     = (fu_i == FU_CSR);
    // units allowed to retire in the second slot
    pairable_o   = clean && (fu_i inside {FU_ALU, FU_LOAD, FU_CTRL_FLOW, FU_MULT});

    // only a store that also retires may reach the store buffer
    assert (!lsu_commit_o || (is_store && retire_ok_o))
      else $error("store commit raised for an entry that cannot retire");
  end

endmodule

// ==== rtl/commit_sequencer.sv ====
// Commit sequencer

`timescale 1ns/1ps

module commit_sequencer
  import commit_pkg::*;
(
  input  logic                                            halt_i,
  input  logic                                            single_step_i,
  // per-port decoder flags
  input  logic [NR_COMMIT_PORTS-1:0]                      retire_ok_i,
  input  logic [NR_COMMIT_PORTS-1:0]                      gpr_write_i,
  input  logic [NR_COMMIT_PORTS-1:0]                      lsu_commit_i,
  input  logic [NR_COMMIT_PORTS-1:0]                      fence_i,
  input  logic [NR_COMMIT_PORTS-1:0]                      fence_i_i,
  input  logic [NR_COMMIT_PORTS-1:0]                      is_csr_i,
  input  logic [NR_COMMIT_PORTS-1:0]                      pairable_i,
  // scoreboard entries
  input  logic [NR_COMMIT_PORTS-1:0]                      commit_valid_i,
  input  fu_e  [NR_COMMIT_PORTS-1:0]                      commit_fu_i,
  input  op_e  [NR_COMMIT_PORTS-1:0]                      commit_op_i,
  input  logic [NR_COMMIT_PORTS-1:0][REG_ADDR_BITS-1:0]   commit_rd_i,
  input  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]            commit_result_i,
  input  logic [NR_COMMIT_PORTS-1:0]                      commit_ex_valid_i,
  input  logic [NR_COMMIT_PORTS-1:0][CAUSE_BITS-1:0]      commit_ex_cause_i,
  input  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]            commit_ex_tval_i,
  input  logic [NR_COMMIT_PORTS-1:0]                      commit_drop_i,
  // csr file
  input  logic [XLEN-1:0]                                 csr_rdata_i,
  input  logic                                            csr_exception_valid_i,
  input  logic [CAUSE_BITS-1:0]                           csr_exception_cause_i,
  output logic [NR_COMMIT_PORTS-1:0]                      commit_ack_o,
  output logic                                            commit_lsu_o,
  output logic                                            commit_csr_o,
  output op_e                                             csr_op_o,
  output logic [XLEN-1:0]                                 csr_wdata_o,
  output logic                                            exception_valid_o,
  output logic [CAUSE_BITS-1:0]                           exception_cause_o,
  output logic [XLEN-1:0]                                 exception_tval_o,
  // write-back requests, registered downstream
  output logic [NR_COMMIT_PORTS-1:0]                      wb_we_o,
  output logic [NR_COMMIT_PORTS-1:0][REG_ADDR_BITS-1:0]   wb_addr_o,
  output logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]            wb_data_o,
  output logic                                            fence_req_o,
  output logic                                            fence_i_req_o
);

  // undropped csr instruction sitting at port 0
  logic csr_at_head;
  // csr file refuses the head instruction
  logic csr_blocked;

  assign csr_at_head = commit_valid_i[0] && !halt_i && !commit_ex_valid_i[0] && is_csr_i[0]
                       && !commit_drop_i[0];
  assign csr_blocked = csr_at_head && csr_exception_valid_i;

  // ------------------------------------------------------------
  // exception selection
  // ------------------------------------------------------------
  always_comb begin
    exception_valid_o = 1'b0;
    exception_cause_o = '0;
    exception_tval_o  = '0;
    if (commit_valid_i[0] && !commit_drop_i[0]) begin
      // csr cause, tval still holds the entry's value
      if (csr_exception_valid_i) begin
        exception_valid_o = 1'b1;
        exception_cause_o = csr_exception_cause_i;
        exception_tval_o  = commit_ex_tval_i[0];
      end
      // earlier exceptions win
      if (commit_ex_valid_i[0]) begin
        exception_valid_o = 1'b1;
        exception_cause_o = commit_ex_cause_i[0];
        exception_tval_o  = commit_ex_tval_i[0];
      end
    end
    // nothing is taken while halted
    if (halt_i) begin
      exception_valid_o = 1'b0;
    end
  end

  // ------------------------------------------------------------
  // in-order acknowledge
  // ------------------------------------------------------------
  always_comb begin
    commit_ack_o[0] = retire_ok_i[0] && !halt_i && !csr_blocked;
    // second slot rides only behind a plain first slot
    commit_ack_o[1] = commit_ack_o[0] && pairable_i[1] && !halt_i && !single_step_i
                      && !is_csr_i[0] && !exception_valid_o;

    // port 1 only with port 0, and never a store or csr in slot 1
    assert (!commit_ack_o[1] ||
            (commit_ack_o[0] && !(commit_fu_i[1] inside {FU_STORE, FU_CSR})))
      else $error("port 1 acknowledged out of order");
  end

  // ------------------------------------------------------------
  // lsu and csr commit
  // ------------------------------------------------------------
  assign commit_lsu_o = lsu_commit_i[0] && !halt_i;
  assign commit_csr_o = csr_at_head && !csr_exception_valid_i;
  // csr no-op unless a csr instruction heads the queue
  assign csr_op_o     = csr_at_head ? commit_op_i[0] : OP_ADD;
  assign csr_wdata_o  = csr_at_head ? commit_result_i[0] : '0;

  // ------------------------------------------------------------
  // register file and fence requests
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
      wb_we_o[i]   = commit_ack_o[i] && gpr_write_i[i];
      wb_addr_o[i] = commit_rd_i[i];
      wb_data_o[i] = commit_result_i[i];
    end
    // csr read value goes to rd instead of the entry result
    if (commit_csr_o) begin
      wb_data_o[0] = csr_rdata_i;
    end
  end

  // fences only ever retire on port 0
  assign fence_req_o   = commit_ack_o[0] && fence_i[0];
  assign fence_i_req_o = commit_ack_o[0] && fence_i_i[0];

endmodule

// ==== rtl/commit_stage.sv ====
// Two-wide commit stage

`timescale 1ns/1ps

module commit_stage
  import commit_pkg::*;
(
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  input  logic                                            halt_i,
  input  logic                                            single_step_i,
  // scoreboard entries, index 0 is the oldest
  input  logic [NR_COMMIT_PORTS-1:0]                      commit_valid_i,
  input  fu_e  [NR_COMMIT_PORTS-1:0]                      commit_fu_i,
  input  op_e  [NR_COMMIT_PORTS-1:0]                      commit_op_i,
  input  logic [NR_COMMIT_PORTS-1:0][REG_ADDR_BITS-1:0]   commit_rd_i,
  input  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]            commit_result_i,
  input  logic [NR_COMMIT_PORTS-1:0]                      commit_ex_valid_i,
  input  logic [NR_COMMIT_PORTS-1:0][CAUSE_BITS-1:0]      commit_ex_cause_i,
  input  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]            commit_ex_tval_i,
  input  logic [NR_COMMIT_PORTS-1:0]                      commit_drop_i,
  input  logic [VLEN-1:0]                                 commit_pc_i,
  input  logic [TRANS_ID_BITS-1:0]                        commit_trans_id_i,
  input  logic                                            commit_lsu_ready_i,
  input  logic                                            no_st_pending_i,
  input  logic [XLEN-1:0]                                 csr_rdata_i,
  input  logic                                            csr_exception_valid_i,
  input  logic [CAUSE_BITS-1:0]                           csr_exception_cause_i,
  output logic [NR_COMMIT_PORTS-1:0]                      commit_ack_o,
  output logic                                            commit_lsu_o,
  output logic                                            commit_csr_o,
  output op_e                                             csr_op_o,
  output logic [XLEN-1:0]                                 csr_wdata_o,
  output logic                                            exception_valid_o,
  output logic [CAUSE_BITS-1:0]                           exception_cause_o,
  output logic [XLEN-1:0]                                 exception_tval_o,
  output logic [VLEN-1:0]                                 pc_o,
  output logic [TRANS_ID_BITS-1:0]                        commit_tran_id_o,
  // register file, one cycle after the acknowledge
  output logic [NR_COMMIT_PORTS-1:0]                      we_gpr_o,
  output logic [NR_COMMIT_PORTS-1:0][REG_ADDR_BITS-1:0]   waddr_o,
  output logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]            wdata_o,
  output logic                                            fence_o,
  output logic                                            fence_i_o
);

  logic [NR_COMMIT_PORTS-1:0] retire_ok;
  logic [NR_COMMIT_PORTS-1:0] gpr_write;
  logic [NR_COMMIT_PORTS-1:0] lsu_commit;
  logic [NR_COMMIT_PORTS-1:0] fence;
  logic [NR_COMMIT_PORTS-1:0] fence_i;
  logic [NR_COMMIT_PORTS-1:0] is_csr;
  logic [NR_COMMIT_PORTS-1:0] pairable;

  logic [NR_COMMIT_PORTS-1:0]                    wb_we;
  logic [NR_COMMIT_PORTS-1:0][REG_ADDR_BITS-1:0] wb_addr;
  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]          wb_data;
  logic                                          fence_req;
  logic                                          fence_i_req;

  // pc and id always follow the oldest entry
  assign pc_o             = commit_pc_i;
  assign commit_tran_id_o = commit_trans_id_i;

  // ------------------------------------------------------------
  // per-port classification
  // ------------------------------------------------------------
  for (genvar i = 0; i < NR_COMMIT_PORTS; i++) begin : gen_decode
    commit_port_decode i_decode (
      .valid_i         (commit_valid_i[i]),
      .fu_i            (commit_fu_i[i]),
      .op_i            (commit_op_i[i]),
      .ex_valid_i      (commit_ex_valid_i[i]),
      .drop_i          (commit_drop_i[i]),
      .lsu_ready_i     (commit_lsu_ready_i),
      .no_st_pending_i (no_st_pending_i),
      .retire_ok_o     (retire_ok[i]),
      .gpr_write_o     (gpr_write[i]),
      .lsu_commit_o    (lsu_commit[i]),
      .fence_o         (fence[i]),
      .fence_i_o       (fence_i[i]),
      .is_csr_o        (is_csr[i]),
      .pairable_o      (pairable[i])
    );
  end

  commit_sequencer i_sequencer (
    .halt_i,
    .single_step_i,
    .retire_ok_i     (retire_ok),
    .gpr_write_i     (gpr_write),
    .lsu_commit_i    (lsu_commit),
    .fence_i         (fence),
    .fence_i_i       (fence_i),
    .is_csr_i        (is_csr),
    .pairable_i      (pairable),
    .commit_valid_i,
    .commit_fu_i,
    .commit_op_i,
    .commit_rd_i,
    .commit_result_i,
    .commit_ex_valid_i,
    .commit_ex_cause_i,
    .commit_ex_tval_i,
    .commit_drop_i,
    .csr_rdata_i,
    .csr_exception_valid_i,
    .csr_exception_cause_i,
    .commit_ack_o,
    .commit_lsu_o,
    .commit_csr_o,
    .csr_op_o,
    .csr_wdata_o,
    .exception_valid_o,
    .exception_cause_o,
    .exception_tval_o,
    .wb_we_o         (wb_we),
    .wb_addr_o       (wb_addr),
    .wb_data_o       (wb_data),
    .fence_req_o     (fence_req),
    .fence_i_req_o   (fence_i_req)
  );

  // ------------------------------------------------------------
  // write-back register
  // ------------------------------------------------------------
  commit_writeback i_writeback (
    .clk_i,
    .reset_i,
    .wb_we_i       (wb_we),
    .wb_addr_i     (wb_addr),
    .wb_data_i     (wb_data),
    .fence_req_i   (fence_req),
    .fence_i_req_i (fence_i_req),
    .we_gpr_o,
    .waddr_o,
    .wdata_o,
    .fence_o,
    .fence_i_o
  );

endmodule

// ==== rtl/commit_writeback.sv ====
// Commit write-back register

`timescale 1ns/1ps

module commit_writeback
  import commit_pkg::*;
(
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  input  logic [NR_COMMIT_PORTS-1:0]                      wb_we_i,
  input  logic [NR_COMMIT_PORTS-1:0][REG_ADDR_BITS-1:0]   wb_addr_i,
  input  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]            wb_data_i,
  input  logic                                            fence_req_i,
  input  logic                                            fence_i_req_i,
  output logic [NR_COMMIT_PORTS-1:0]                      we_gpr_o,
  output logic [NR_COMMIT_PORTS-1:0][REG_ADDR_BITS-1:0]   waddr_o,
  output logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]            wdata_o,
  output logic                                            fence_o,
  output logic                                            fence_i_o
);

  // ------------------------------------------------------------
  // enables and strobes
  // ------------------------------------------------------------
  // refilled every cycle, so a request becomes a single-cycle pulse
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      we_gpr_o  <= '0;
      fence_o   <= 1'b0;
      fence_i_o <= 1'b0;
    end else begin
      we_gpr_o  <= wb_we_i;
      fence_o   <= fence_req_i;
      fence_i_o <= fence_i_req_i;
    end
  end

  // ------------------------------------------------------------
  // address and data
  // ------------------------------------------------------------
  // qualified by we_gpr_o downstream
  always_ff @(posedge clk_i) begin
    waddr_o <= wb_addr_i;
    wdata_o <= wb_data_i;
  end

  // one port-0 entry cannot be both fence kinds
  a_fence_onehot : assert property (@(posedge clk_i) disable iff (reset_i)
    !(fence_o && fence_i_o))
    else $error("fence and fence.i pulsed together");

endmodule

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the commit stage testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_commit_stage \
  -f tb.f \
  --Mdir "$BUILD_DIR" -o sim_commit
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/sim_commit" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== tb.f ====
rtl/commit_pkg.sv
rtl/commit_port_decode.sv
rtl/commit_sequencer.sv
rtl/commit_writeback.sv
rtl/commit_stage.sv
tb/tb_clock_gen.sv
tb/tb_commit_stage.sv

// ==== tb/commit_input.txt ====
# id rnd val fu0 fu1 op0 op1 rd0 rd1 res0 res1 exv cau0 tval0 drop halt ss rdy nsp rdat cexv ccau
#   then ack lsu csr cop cwd exv cau tval, then next cycle we wa0 wa1 wd0 wd1 fence fence_i
1 1 3 1 2 0 0 5 6 0 0 0 0 0 0 0 0 1 1 0 0 0  3 0 0 0 0 0 0 0  3 5 6 0 0 0 0
1 1 3 4 5 0 0 7 8 0 0 0 0 0 0 0 0 1 1 0 0 0  3 0 0 0 0 0 0 0  3 7 8 0 0 0 0
1 0 3 1 1 0 0 9 a 11 22 0 0 0 0 0 1 1 1 0 0 0  1 0 0 0 0 0 0 0  1 9 0 11 0 0 0
2 0 1 3 0 0 0 0 0 33 0 0 0 0 0 0 0 0 1 0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 0
2 0 1 3 0 0 0 0 0 33 0 0 0 0 0 0 0 1 1 0 0 0  1 1 0 0 0 0 0 0  1 0 0 33 0 0 0
2 0 3 3 1 0 0 0 4 33 44 0 0 0 0 0 0 1 1 0 0 0  3 1 0 0 0 0 0 0  3 0 4 33 44 0 0
3 0 3 6 1 1 0 3 4 55 66 0 0 0 0 0 0 1 1 77 0 0  1 0 1 1 55 0 0 0  1 3 0 77 0 0 0
3 0 1 6 0 2 0 3 0 55 0 0 0 99 0 0 0 1 1 77 1 2  0 0 0 2 55 1 2 99  0 0 0 0 0 0 0
4 0 1 0 0 4 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 0
4 0 1 0 0 4 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0  1 0 0 0 0 0 0 0  1 0 0 0 0 1 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 0
4 0 1 0 0 5 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 0
4 0 1 0 0 5 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0  1 0 0 0 0 0 0 0  1 0 0 0 0 0 1
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 0
5 0 3 2 1 0 0 1 2 11 22 1 5 abc 0 0 0 1 1 0 0 0  0 0 0 0 0 1 5 abc  0 0 0 0 0 0 0
5 0 1 2 0 0 0 1 0 11 0 1 5 abc 0 0 0 1 1 0 1 2  0 0 0 0 0 1 5 abc  0 0 0 0 0 0 0
5 0 3 2 1 0 0 1 2 11 22 1 5 abc 1 0 0 1 1 0 0 0  3 0 0 0 0 0 0 0  2 0 2 0 22 0 0
5 0 3 1 1 0 0 1 2 11 22 2 0 0 0 0 0 1 1 0 0 0  1 0 0 0 0 0 0 0  1 1 0 11 0 0 0
5 1 1 1 0 0 0 1 0 0 0 1 7 0 0 0 0 1 1 0 0 0  0 0 0 0 0 1 7 0  0 0 0 0 0 0 0
6 0 3 1 1 0 0 1 2 11 22 0 0 0 0 1 0 1 1 0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 0
6 0 1 1 0 0 0 1 0 11 0 1 5 abc 0 1 0 1 1 0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 0
6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 0

// ==== tb/tb_clock_gen.sv ====
// Testbench clock and reset

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  // 8 ns period
  localparam real HALF_PERIOD = 4.0;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // reset held for four rising edges, dropped just after the fourth
  initial begin
    reset_o = 1'b1;
    repeat (4) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== tb/tb_commit_stage.sv ====
// Commit stage testbench

`timescale 1ns/1ps

module tb_commit_stage
  import commit_pkg::*;
();

  // fields per vector line
  localparam int NF = 37;
  // guards against a file without an end
  localparam int MAX_LINES = 500;
  localparam int RESET_TIMEOUT = 20;

  logic clk;
  logic reset;

  logic                                          halt;
  logic                                          single_step;
  logic [NR_COMMIT_PORTS-1:0]                    commit_valid;
  fu_e  [NR_COMMIT_PORTS-1:0]                    commit_fu;
  op_e  [NR_COMMIT_PORTS-1:0]                    commit_op;
  logic [NR_COMMIT_PORTS-1:0][REG_ADDR_BITS-1:0] commit_rd;
  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]          commit_result;
  logic [NR_COMMIT_PORTS-1:0]                    commit_ex_valid;
  logic [NR_COMMIT_PORTS-1:0][CAUSE_BITS-1:0]    commit_ex_cause;
  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]          commit_ex_tval;
  logic [NR_COMMIT_PORTS-1:0]                    commit_drop;
  logic [VLEN-1:0]                               commit_pc;
  logic [TRANS_ID_BITS-1:0]                      commit_trans_id;
  logic                                          lsu_ready;
  logic                                          no_st_pending;
  logic [XLEN-1:0]                               csr_rdata;
  logic                                          csr_ex_valid;
  logic [CAUSE_BITS-1:0]                         csr_ex_cause;

  logic [NR_COMMIT_PORTS-1:0]                    commit_ack;
  logic                                          commit_lsu;
  logic                                          commit_csr;
  op_e                                           csr_op;
  logic [XLEN-1:0]                               csr_wdata;
  logic                                          exception_valid;
  logic [CAUSE_BITS-1:0]                         exception_cause;
  logic [XLEN-1:0]                               exception_tval;
  logic [VLEN-1:0]                               pc;
  logic [TRANS_ID_BITS-1:0]                      tran_id;
  logic [NR_COMMIT_PORTS-1:0]                    we_gpr;
  logic [NR_COMMIT_PORTS-1:0][REG_ADDR_BITS-1:0] waddr;
  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]          wdata;
  logic                                          fence;
  logic                                          fence_i;

  // parsed vector fields
  logic [31:0] fld [NF];
  // registered expectations of the previous line
  logic [31:0] exp_reg [7];
  integer seed = 16608;
  int errors;
  int checks;
  int test_errors;
  int test_checks;

  tb_clock_gen i_clk_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  commit_stage i_dut (
    .clk_i                 (clk),
    .reset_i               (reset),
    .halt_i                (halt),
    .single_step_i         (single_step),
    .commit_valid_i        (commit_valid),
    .commit_fu_i           (commit_fu),
    .commit_op_i           (commit_op),
    .commit_rd_i           (commit_rd),
    .commit_result_i       (commit_result),
    .commit_ex_valid_i     (commit_ex_valid),
    .commit_ex_cause_i     (commit_ex_cause),
    .commit_ex_tval_i      (commit_ex_tval),
    .commit_drop_i         (commit_drop),
    .commit_pc_i           (commit_pc),
    .commit_trans_id_i     (commit_trans_id),
    .commit_lsu_ready_i    (lsu_ready),
    .no_st_pending_i       (no_st_pending),
    .csr_rdata_i           (csr_rdata),
    .csr_exception_valid_i (csr_ex_valid),
    .csr_exception_cause_i (csr_ex_cause),
    .commit_ack_o          (commit_ack),
    .commit_lsu_o          (commit_lsu),
    .commit_csr_o          (commit_csr),
    .csr_op_o              (csr_op),
    .csr_wdata_o           (csr_wdata),
    .exception_valid_o     (exception_valid),
    .exception_cause_o     (exception_cause),
    .exception_tval_o      (exception_tval),
    .pc_o                  (pc),
    .commit_tran_id_o      (tran_id),
    .we_gpr_o              (we_gpr),
    .waddr_o               (waddr),
    .wdata_o               (wdata),
    .fence_o               (fence),
    .fence_i_o             (fence_i)
  );

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    test_checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  // splits a line into hex numbers, returns how many were found
  task automatic parse_line(input string s, output int n);
    logic [31:0] acc;
    bit          in_tok;
    byte         c;
    int          d;
    n = 0;
    acc = '0;
    in_tok = 0;
    for (int i = 0; i <= s.len(); i++) begin
      c = (i < s.len()) ? s[i] : 8'h20;
      d = -1;
      if (c >= "0" && c <= "9") d = c - "0";
      if (c >= "a" && c <= "f") d = c - "a" + 10;
      if (c >= "A" && c <= "F") d = c - "A" + 10;
      if (d >= 0) begin
        acc = (acc << 4) | d;
        in_tok = 1;
      end else if (in_tok) begin
        if (n < NF) fld[n] = acc;
        n++;
        acc = '0;
        in_tok = 0;
      end
    end
  endtask

  function automatic string test_name(input int id);
    case (id)
      1: test_name = "dual retire";
      2: test_name = "store back-pressure";
      3: test_name = "csr commit";
      4: test_name = "fences";
      5: test_name = "exceptions and drop";
      6: test_name = "halt";
      default: test_name = "reset";
    endcase
  endfunction

  task automatic report_test(input int id);
    $display("test %0d %s: %0d checks, %0s", id, test_name(id), test_checks,
             (test_errors == 0) ? "ok" : "FAILED");
    test_errors = 0;
    test_checks = 0;
  endtask

  task automatic drive_idle();
    halt            = 1'b0;
    single_step     = 1'b0;
    commit_valid    = '0;
    commit_fu[0]    = FU_NONE;
    commit_fu[1]    = FU_NONE;
    commit_op[0]    = OP_ADD;
    commit_op[1]    = OP_ADD;
    commit_rd       = '0;
    commit_result   = '0;
    commit_ex_valid = '0;
    commit_ex_cause = '0;
    commit_ex_tval  = '0;
    commit_drop     = '0;
    commit_pc       = '0;
    commit_trans_id = '0;
    lsu_ready       = 1'b1;
    no_st_pending   = 1'b1;
    csr_rdata       = '0;
    csr_ex_valid    = 1'b0;
    csr_ex_cause    = '0;
  endtask

  // ------------------------------------------------------------
  // vector fields to DUT inputs
  // ------------------------------------------------------------
  task automatic drive_line(input int line_no);
    // lines marked random draw their own results and tval
    if (fld[1] != 0) begin
      fld[9]  = $random(seed);
      fld[10] = $random(seed);
      fld[13] = $random(seed);
    end
    commit_valid       = fld[2][1:0];
    commit_fu[0]       = fu_e'(fld[3][2:0]);
    commit_fu[1]       = fu_e'(fld[4][2:0]);
    commit_op[0]       = op_e'(fld[5][2:0]);
    commit_op[1]       = op_e'(fld[6][2:0]);
    commit_rd[0]       = fld[7][REG_ADDR_BITS-1:0];
    commit_rd[1]       = fld[8][REG_ADDR_BITS-1:0];
    commit_result[0]   = fld[9];
    commit_result[1]   = fld[10];
    commit_ex_valid    = fld[11][1:0];
    commit_ex_cause[0] = fld[12][CAUSE_BITS-1:0];
    commit_ex_cause[1] = '0;
    commit_ex_tval[0]  = fld[13];
    commit_ex_tval[1]  = '0;
    commit_drop        = fld[14][1:0];
    halt               = fld[15][0];
    single_step        = fld[16][0];
    lsu_ready          = fld[17][0];
    no_st_pending      = fld[18][0];
    csr_rdata          = fld[19];
    csr_ex_valid       = fld[20][0];
    csr_ex_cause       = fld[21][CAUSE_BITS-1:0];
    // pc and id follow the line number
    commit_pc          = 32'h8000_0000 + 32'(line_no * 4);
    commit_trans_id    = line_no[TRANS_ID_BITS-1:0];
    // derived data expectations for random lines
    if (fld[1] != 0) begin
      fld[26] = (fld[25] != 0) ? fld[9] : 32'h0;
      fld[29] = (fld[27] != 0) ? fld[13] : fld[29];
      fld[33] = (fld[24] != 0) ? fld[19] : fld[9];
      fld[34] = fld[10];
    end
  endtask

  task automatic check_comb(input int line_no);
    check_value("commit_ack", commit_ack, fld[22]);
    check_value("commit_lsu", commit_lsu, fld[23]);
    check_value("commit_csr", commit_csr, fld[24]);
    check_value("csr_op", csr_op, fld[25]);
    check_value("csr_wdata", csr_wdata, fld[26]);
    check_value("exception_valid", exception_valid, fld[27]);
    if (fld[27] != 0) begin
      check_value("exception_cause", exception_cause, fld[28]);
      check_value("exception_tval", exception_tval, fld[29]);
    end
    check_value("pc", pc, 32'h8000_0000 + 32'(line_no * 4));
    check_value("trans id", tran_id, line_no[TRANS_ID_BITS-1:0]);
  endtask

  // registered outputs of the previous vector line
  task automatic check_registered();
    check_value("we_gpr", we_gpr, exp_reg[0]);
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
      if (exp_reg[0][i]) begin
        check_value($sformatf("waddr[%0d]", i), waddr[i], exp_reg[1+i]);
        check_value($sformatf("wdata[%0d]", i), wdata[i], exp_reg[3+i]);
      end
    end
    check_value("fence", fence, exp_reg[5]);
    check_value("fence_i", fence_i, exp_reg[6]);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    int    fd;
    int    n;
    int    line_no;
    int    lines_read;
    int    cur_id;
    int    wait_cycles;
    bit    have_prev;
    bit    timed_out;
    string line;

    errors = 0;
    checks = 0;
    test_errors = 0;
    test_checks = 0;
    have_prev = 0;
    timed_out = 0;
    line_no = 0;
    lines_read = 0;
    cur_id = 0;
    drive_idle();
    // a full pair with a fence at the head, held while reset is high
    commit_valid = 2'b11;
    commit_fu[0] = FU_ALU;
    commit_fu[1] = FU_ALU;
    commit_op[0] = OP_FENCE;

    fd = $fopen("tb/commit_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file tb/commit_input.txt");
      errors++;
    end else begin
      wait_cycles = 0;
      // reset drops just after a rising edge, so it is stable here
      @(negedge clk);
      while (reset && wait_cycles < RESET_TIMEOUT) begin
        @(negedge clk);
        wait_cycles++;
      end
      if (reset) begin
        $display("timeout: reset never released");
        timed_out = 1;
      end else begin
        // enables and strobes stay cleared although the inputs request writes
        check_value("we_gpr after reset", we_gpr, 0);
        check_value("fence after reset", fence, 0);
        check_value("fence_i after reset", fence_i, 0);
        report_test(0);

        while (!$feof(fd) && lines_read < MAX_LINES) begin
          lines_read++;
          line = "";
          if ($fgets(line, fd) == 0) continue;
          if (line.len() < 2 || line[0] == "#") continue;
          parse_line(line, n);
          if (n != NF) begin
            $display("malformed vector line: %0d fields instead of %0d", n, NF);
            errors++;
            continue;
          end
          if (cur_id != 0 && fld[0] != cur_id) report_test(cur_id);
          cur_id = fld[0];
          line_no++;
          drive_line(line_no);
          // sample just before the rising edge
          #3;
          check_comb(line_no);
          if (have_prev) check_registered();
          for (int k = 0; k < 7; k++) exp_reg[k] = fld[30+k];
          have_prev = 1;
          @(negedge clk);
        end
        if (!$feof(fd)) begin
          $display("timeout: no end of vector file after %0d lines", MAX_LINES);
          timed_out = 1;
        end
        drive_idle();
        #3;
        if (have_prev) check_registered();
        if (cur_id != 0) report_test(cur_id);
      end
      $fclose(fd);
    end

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
